// File: hw/axi_rd_pkg.sv
// AXI4 read master shared definitions
// Widths, burst geometry and common types for the read path
package axi_rd_pkg;

  ////////////////////////////////////////
  // Interface widths
  localparam int unsigned ADDR_W          = 32;
  localparam int unsigned DATA_W          = 32;
  localparam int unsigned XFER_SIZE_W     = 20;
  localparam int unsigned DW_BYTES        = DATA_W / 8;
  localparam int unsigned LOG_DW_BYTES    = $clog2(DW_BYTES);

  ////////////////////////////////////////
  // Burst geometry
  localparam int unsigned BURST_LEN       = 256;
  localparam int unsigned LOG_BURST_LEN   = $clog2(BURST_LEN);
  // Full burst size, also the alignment and address step
  localparam int unsigned BURST_BYTES     = BURST_LEN * DW_BYTES;
  localparam int unsigned MAX_OUTSTANDING = 4;
  localparam int unsigned OUTST_W         = $clog2(MAX_OUTSTANDING + 1);
  localparam int unsigned TOTAL_LEN_W     = XFER_SIZE_W - LOG_DW_BYTES;
  localparam int unsigned TXN_CNT_W       = TOTAL_LEN_W - LOG_BURST_LEN;

  // Data FIFO holds every outstanding burst
  localparam int unsigned FIFO_DEPTH      = BURST_LEN * MAX_OUTSTANDING;
  localparam int unsigned FIFO_AW         = $clog2(FIFO_DEPTH);

  typedef logic [ADDR_W-1:0]        addr_t;
  typedef logic [DATA_W-1:0]        data_t;
  typedef logic [XFER_SIZE_W-1:0]   xfer_size_t;
  // Beat count minus one
  typedef logic [TOTAL_LEN_W-1:0]   total_len_t;
  // Burst count minus one
  typedef logic [TXN_CNT_W-1:0]     txn_cnt_t;
  typedef logic [LOG_BURST_LEN-1:0] burst_len_t;

  typedef enum logic {AR_IDLE, AR_ACTIVE} ar_state_t;

endpackage

// File: hw/txn_counter.sv
// Loadable up/down counter with zero flag
// Tracks burst and vacancy counts in the read master
module txn_counter #(
  parameter int unsigned      WIDTH = 8,
  parameter logic [WIDTH-1:0] INIT  = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [WIDTH-1:0] load_value,
  output logic [WIDTH-1:0] count,
  output logic             is_zero
);

  // Load wins, simultaneous incr and decr cancel out
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= INIT;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + 1'b1;
    end else if (decr && !incr) begin
      count <= count - 1'b1;
    end
  end

  assign is_zero = (count == '0);

endmodule

// File: hw/xfer_setup.sv
// Transfer request setup
// Captures start address and byte count, rounds to beats and splits into bursts
module xfer_setup import axi_rd_pkg::*; (
  input  logic       aclk,
  input  logic       areset,
  input  logic       ctrl_start,
  input  addr_t      ctrl_addr_offset,
  input  xfer_size_t ctrl_xfer_size,
  output logic       setup_start,
  output addr_t      base_addr,
  output txn_cnt_t   num_txn,
  output burst_len_t final_len
);

  logic       start_d1;
  total_len_t total_len_r;

  // Start pulse delay line
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1    <= 1'b0;
      setup_start <= 1'b0;
    end else begin
      start_d1    <= ctrl_start;
      setup_start <= start_d1;
    end
  end

  ////////////////////////////////////////
  // Request capture
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Round up to whole beats, arlen style (count minus one)
      if (ctrl_xfer_size[LOG_DW_BYTES-1:0] != '0) begin
        total_len_r <= ctrl_xfer_size[LOG_DW_BYTES +: TOTAL_LEN_W];
      end else begin
        total_len_r <= ctrl_xfer_size[LOG_DW_BYTES +: TOTAL_LEN_W] - 1'b1;
      end
      // Align down to the burst size
      base_addr <= ctrl_addr_offset & ~addr_t'(BURST_BYTES - 1);
    end
  end

  // Low bits give the length of the last burst
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      final_len <= total_len_r[LOG_BURST_LEN-1:0];
    end
  end

  // Upper bits give the burst count minus one
  assign num_txn = total_len_r[LOG_BURST_LEN +: TXN_CNT_W];

endmodule

// File: hw/ar_issue.sv
// AXI4 read address issuer
// Walks burst addresses and throttles to the outstanding burst limit
module ar_issue import axi_rd_pkg::*; (
  input  logic       aclk,
  input  logic       areset,
  input  logic       setup_start,
  input  addr_t      base_addr,
  input  txn_cnt_t   num_txn,
  input  burst_len_t final_len,
  input  logic       burst_drained,
  output logic       m_axi_arvalid,
  input  logic       m_axi_arready,
  output addr_t      m_axi_araddr,
  output burst_len_t m_axi_arlen
);

  ar_state_t            state;
  logic                 arxfer;
  logic                 final_burst;
  logic                 stall_ar;
  logic [OUTST_W-1:0]   vacancy_cnt;

  assign arxfer = m_axi_arvalid & m_axi_arready;

  ////////////////////////////////////////
  // Issue state
  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= AR_IDLE;
    end else if (setup_start) begin
      state <= AR_ACTIVE;
    end else if (final_burst && arxfer) begin
      state <= AR_IDLE;
    end
  end

  // Raise arvalid when active with room, drop after handshake
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_arvalid <= 1'b0;
    end else if (state == AR_ACTIVE && !stall_ar && !m_axi_arvalid) begin
      m_axi_arvalid <= 1'b1;
    end else if (m_axi_arready) begin
      m_axi_arvalid <= 1'b0;
    end
  end

  // Burst address, one full burst per accepted request
  always_ff @(posedge aclk) begin
    if (setup_start) begin
      m_axi_araddr <= base_addr;
    end else if (arxfer) begin
      m_axi_araddr <= m_axi_araddr + addr_t'(BURST_BYTES);
    end
  end

  // Only the last burst may be short
  assign m_axi_arlen = final_burst ? final_len : burst_len_t'(BURST_LEN - 1);

  ////////////////////////////////////////
  // Remaining bursts, zero on the final one
  txn_counter #(
    .WIDTH (TXN_CNT_W),
    .INIT  ('0)
  ) u_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (setup_start),
    .incr       (1'b0),
    .decr       (arxfer),
    .load_value (num_txn),
    .count      (),
    .is_zero    (final_burst)
  );

  // Free FIFO burst slots, refilled as the stream drains
  txn_counter #(
    .WIDTH (OUTST_W),
    .INIT  (OUTST_W'(MAX_OUTSTANDING))
  ) u_vacancy_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_drained),
    .decr       (arxfer),
    .load_value ('0),
    .count      (vacancy_cnt),
    .is_zero    (stall_ar)
  );

endmodule

// File: hw/r_tracker.sv
// Read response tracker
// Counts finished R bursts and pulses done after the last one
module r_tracker import axi_rd_pkg::*; (
  input  logic     aclk,
  input  logic     areset,
  input  logic     setup_start,
  input  txn_cnt_t num_txn,
  input  logic     r_last_beat,
  output logic     ctrl_done
);

  logic final_burst;

  // Bursts still to complete on R
  txn_counter #(
    .WIDTH (TXN_CNT_W),
    .INIT  ('0)
  ) u_r_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (setup_start),
    .incr       (1'b0),
    .decr       (r_last_beat),
    .load_value (num_txn),
    .count      (),
    .is_zero    (final_burst)
  );

  ////////////////////////////////////////
  // Done pulse
  // Counter wraps past zero on the last rlast, so this stays one cycle
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= r_last_beat & final_burst;
    end
  end

endmodule

// File: hw/rdata_fifo.sv
// Read data FIFO, first word fall through
// Buffers R beats for the stream port and flags each drained burst
module rdata_fifo import axi_rd_pkg::*; (
  input  logic  aclk,
  input  logic  areset,
  input  logic  wr_valid,
  input  data_t wr_data,
  input  logic  wr_last,
  output logic  m_axis_tvalid,
  input  logic  m_axis_tready,
  output data_t m_axis_tdata,
  output logic  m_axis_tlast,
  output logic  burst_drained
);

  // Extra pointer bit tells full from empty
  logic [FIFO_AW:0] wr_ptr;
  logic [FIFO_AW:0] rd_ptr;
  logic             rd_en;

  data_t mem_data [FIFO_DEPTH];
  logic  mem_last [FIFO_DEPTH];

  ////////////////////////////////////////
  // Write side
  // Sized for every outstanding burst, never full on a write
  always_ff @(posedge aclk) begin
    if (wr_valid) begin
      mem_data[wr_ptr[FIFO_AW-1:0]] <= wr_data;
      mem_last[wr_ptr[FIFO_AW-1:0]] <= wr_last;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
    end else if (wr_valid) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Read side
  // Head entry shows as soon as it is written
  assign m_axis_tvalid = (wr_ptr != rd_ptr);
  assign m_axis_tdata  = mem_data[rd_ptr[FIFO_AW-1:0]];
  assign m_axis_tlast  = mem_last[rd_ptr[FIFO_AW-1:0]];

  assign rd_en = m_axis_tvalid & m_axis_tready;

  always_ff @(posedge aclk) begin
    if (areset) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Last beat of a burst leaves, one burst slot frees up
  assign burst_drained = rd_en & m_axis_tlast;

endmodule

// File: hw/axi_read_master.sv
// AXI4 read master top
// Splits a request into aligned bursts and streams the read data out
module axi_read_master import axi_rd_pkg::*; (
  input  logic       aclk,
  input  logic       areset,
  // Control
  input  logic       ctrl_start,
  input  addr_t      ctrl_addr_offset,
  input  xfer_size_t ctrl_xfer_size,
  output logic       ctrl_done,
  // AR channel
  output logic       m_axi_arvalid,
  input  logic       m_axi_arready,
  output addr_t      m_axi_araddr,
  output burst_len_t m_axi_arlen,
  // R channel
  input  logic       m_axi_rvalid,
  output logic       m_axi_rready,
  input  data_t      m_axi_rdata,
  input  logic       m_axi_rlast,
  // Stream out
  output logic       m_axis_tvalid,
  input  logic       m_axis_tready,
  output data_t      m_axis_tdata,
  output logic       m_axis_tlast
);

  logic       setup_start;
  addr_t      base_addr;
  txn_cnt_t   num_txn;
  burst_len_t final_len;
  logic       burst_drained;
  logic       r_last_beat;

  // FIFO has room for all outstanding bursts
  assign m_axi_rready = 1'b1;
  assign r_last_beat  = m_axi_rvalid & m_axi_rlast;

  ////////////////////////////////////////
  xfer_setup u_xfer_setup (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size   (ctrl_xfer_size),
    .setup_start      (setup_start),
    .base_addr        (base_addr),
    .num_txn          (num_txn),
    .final_len        (final_len)
  );

  ar_issue u_ar_issue (
    .aclk          (aclk),
    .areset        (areset),
    .setup_start   (setup_start),
    .base_addr     (base_addr),
    .num_txn       (num_txn),
    .final_len     (final_len),
    .burst_drained (burst_drained),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen)
  );

  r_tracker u_r_tracker (
    .aclk        (aclk),
    .areset      (areset),
    .setup_start (setup_start),
    .num_txn     (num_txn),
    .r_last_beat (r_last_beat),
    .ctrl_done   (ctrl_done)
  );

  // Every R beat is accepted straight into the FIFO
  rdata_fifo u_rdata_fifo (
    .aclk          (aclk),
    .areset        (areset),
    .wr_valid      (m_axi_rvalid),
    .wr_data       (m_axi_rdata),
    .wr_last       (m_axi_rlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .burst_drained (burst_drained)
  );

endmodule

// File: sim/axi_read_master_props.sv
// AXI read master protocol checks
// AR hold rules, outstanding burst window and done pulse width
module axi_read_master_props import axi_rd_pkg::*; (
  input  logic               aclk,
  input  logic               areset,
  input  logic               arvalid,
  input  logic               arready,
  input  addr_t              araddr,
  input  burst_len_t         arlen,
  input  logic [OUTST_W-1:0] vacancy_cnt,
  input  logic               done
);
  timeunit 1ns;
  timeprecision 1ps;

  // Request must wait, unchanged, for arready
  ar_hold: assert property (@(posedge aclk) disable iff (areset)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
    else $error("AR request dropped or changed before arready");

  // Unsigned count, an underflow shows up as a large value
  vacancy_range: assert property (@(posedge aclk) disable iff (areset)
    vacancy_cnt <= OUTST_W'(MAX_OUTSTANDING))
    else $error("Vacancy count outside 0 to MAX_OUTSTANDING");

  done_width: assert property (@(posedge aclk) disable iff (areset)
    done |=> !done)
    else $error("ctrl_done held high for two cycles");

endmodule

// Attached at the top so done and the issuer share one checker
bind axi_read_master axi_read_master_props u_props (
  .aclk        (aclk),
  .areset      (areset),
  .arvalid     (m_axi_arvalid),
  .arready     (m_axi_arready),
  .araddr      (m_axi_araddr),
  .arlen       (m_axi_arlen),
  .vacancy_cnt (u_ar_issue.vacancy_cnt),
  .done        (ctrl_done)
);

// File: sim/tb_axi_read_master.sv
// AXI read master testbench
// Memory slave model, stream sink and directed request tests
module tb_axi_read_master import axi_rd_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned BEAT_BYTES  = DATA_W / 8;
  localparam int unsigned BURST_SPAN  = BURST_LEN * BEAT_BYTES;
  localparam int unsigned FIFO_BEATS  = BURST_LEN * MAX_OUTSTANDING;
  localparam int unsigned WAIT_LIMIT  = 100000;
  localparam int unsigned WAIT_DONE   = 0;
  localparam int unsigned WAIT_R      = 1;
  localparam int unsigned WAIT_STREAM = 2;
  // Sink tready modes
  localparam logic [1:0] SINK_HOLD   = 2'd0;
  localparam logic [1:0] SINK_OPEN   = 2'd1;
  localparam logic [1:0] SINK_RANDOM = 2'd2;

  logic       aclk             = 1'b0;
  logic       areset           = 1'b1;
  logic       ctrl_start       = 1'b0;
  addr_t      ctrl_addr_offset = '0;
  xfer_size_t ctrl_xfer_size   = '0;
  logic       ctrl_done;
  logic       m_axi_arvalid;
  logic       m_axi_arready    = 1'b0;
  addr_t      m_axi_araddr;
  burst_len_t m_axi_arlen;
  logic       m_axi_rvalid     = 1'b0;
  logic       m_axi_rready;
  data_t      m_axi_rdata      = '0;
  logic       m_axi_rlast      = 1'b0;
  logic       m_axis_tvalid;
  logic       m_axis_tready    = 1'b0;
  data_t      m_axis_tdata;
  logic       m_axis_tlast;

  logic [1:0]  sink_mode = SINK_OPEN;
  logic [31:0] lcg_state = 32'had94_e428;
  int unsigned errors     = 0;
  logic        timed_out  = 1'b0;
  int unsigned r_accepted = 0;
  int unsigned done_count = 0;
  // Slave side pending reads
  addr_t       r_addr;
  int unsigned r_beats_left = 0;
  addr_t       ar_addr_q[$];
  burst_len_t  ar_len_q[$];
  // Observed and expected traffic over all tests
  addr_t       seen_addr_q[$];
  burst_len_t  seen_len_q[$];
  data_t       got_data_q[$];
  logic        got_last_q[$];
  addr_t       exp_addr_q[$];
  burst_len_t  exp_len_q[$];
  data_t       exp_data_q[$];
  logic        exp_last_q[$];
  // Queue positions where the current test begins
  int unsigned base_exp_ar;
  int unsigned base_seen_ar;
  int unsigned base_exp_beat;
  int unsigned base_got_beat;
  int unsigned base_r;
  int unsigned base_done;

  axi_read_master dut (.*);

  always #4 aclk = ~aclk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  ////////////////////////////////////////
  // Memory slave returning each beat's byte address as data
  always @(posedge aclk) begin : slave_model
    logic [31:0] rnd;
    rnd = lcg_next();
    if (areset) begin
      m_axi_arready <= 1'b0;
      m_axi_rvalid  <= 1'b0;
      m_axi_rlast   <= 1'b0;
      r_beats_left = 0;
    end else begin
      m_axi_arready <= rnd[28];
      if (m_axi_arvalid && m_axi_arready) begin
        ar_addr_q.push_back(m_axi_araddr);
        ar_len_q.push_back(m_axi_arlen);
        seen_addr_q.push_back(m_axi_araddr);
        seen_len_q.push_back(m_axi_arlen);
      end
      if (m_axi_rvalid && m_axi_rready) begin
        r_accepted++;
      end
      if (r_beats_left == 0 && ar_addr_q.size() != 0) begin
        r_addr       = ar_addr_q.pop_front();
        r_beats_left = 32'(ar_len_q.pop_front()) + 1;
      end
      // Gaps in rvalid about one cycle in four
      if (r_beats_left != 0 && rnd[31:30] != 2'b00) begin
        m_axi_rvalid <= 1'b1;
        m_axi_rdata  <= data_t'(r_addr);
        m_axi_rlast  <= (r_beats_left == 1);
        r_addr       = r_addr + addr_t'(BEAT_BYTES);
        r_beats_left--;
      end else begin
        m_axi_rvalid <= 1'b0;
        m_axi_rlast  <= 1'b0;
      end
    end
  end

  // Stream sink
  always @(posedge aclk) begin : stream_sink
    logic [31:0] rnd;
    rnd = lcg_next();
    if (!areset && m_axis_tvalid && m_axis_tready) begin
      got_data_q.push_back(m_axis_tdata);
      got_last_q.push_back(m_axis_tlast);
    end
    if (areset || sink_mode == SINK_HOLD) begin
      m_axis_tready <= 1'b0;
    end else if (sink_mode == SINK_OPEN) begin
      m_axis_tready <= 1'b1;
    end else begin
      m_axis_tready <= rnd[31];
    end
  end

  always @(posedge aclk) begin
    if (!areset && ctrl_done) begin
      done_count++;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s got=0x%08h exp=0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_len(string name, burst_len_t got, burst_len_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    end
  endtask

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s got=0x%08h exp=0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_last(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  task automatic report(string msg);
    errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  ////////////////////////////////////////
  // Request helpers
  task automatic mark_test_start();
    base_exp_ar   = exp_addr_q.size();
    base_seen_ar  = seen_addr_q.size();
    base_exp_beat = exp_data_q.size();
    base_got_beat = got_data_q.size();
    base_r        = r_accepted;
    base_done     = done_count;
  endtask

  // Expected bursts from the aligned base and the beat count rounded up
  task automatic run_request(addr_t offset, xfer_size_t size);
    addr_t       addr;
    int unsigned left;
    int unsigned n;
    int unsigned i;
    addr = offset & ~(addr_t'(BURST_SPAN) - addr_t'(1));
    left = (32'(size) + BEAT_BYTES - 1) / BEAT_BYTES;
    while (left != 0) begin
      n = (left > BURST_LEN) ? BURST_LEN : left;
      exp_addr_q.push_back(addr);
      exp_len_q.push_back(burst_len_t'(n - 1));
      for (i = 0; i < n; i++) begin
        exp_data_q.push_back(data_t'(addr + addr_t'(i * BEAT_BYTES)));
        exp_last_q.push_back(i == n - 1);
      end
      addr = addr + addr_t'(BURST_SPAN);
      left = left - n;
    end
    @(posedge aclk);
    ctrl_start       <= 1'b1;
    ctrl_addr_offset <= offset;
    ctrl_xfer_size   <= size;
    @(posedge aclk);
    ctrl_start <= 1'b0;
  endtask

  task automatic wait_until(int unsigned what, int unsigned target, string label);
    int unsigned cycles;
    logic        reached;
    cycles  = 0;
    reached = 1'b0;
    while (!timed_out && !reached) begin
      @(posedge aclk);
      case (what)
        WAIT_DONE: reached = ctrl_done;
        WAIT_R:    reached = (r_accepted - base_r) >= target;
        default:   reached = (got_data_q.size() - base_got_beat) >= target;
      endcase
      cycles++;
      if (!reached && cycles >= WAIT_LIMIT) begin
        timed_out = 1'b1;
        report($sformatf("Timed out waiting for %s", label));
      end
    end
  endtask

  // Done must follow the last R beat of the request
  task automatic wait_request_done();
    wait_until(WAIT_DONE, 0, "ctrl_done");
    if (!timed_out && (r_accepted - base_r) != (exp_data_q.size() - base_exp_beat)) begin
      report($sformatf("ctrl_done after %0d of %0d R beats", r_accepted - base_r,
                       exp_data_q.size() - base_exp_beat));
    end
  endtask

  task automatic drain_and_verify(int unsigned requests);
    int unsigned n_exp;
    int unsigned n_got;
    int unsigned i;
    wait_until(WAIT_STREAM, exp_data_q.size() - base_exp_beat, "stream beats");
    // Quiet window catches extra beats or a second done
    repeat (32) @(posedge aclk);
    n_exp = exp_addr_q.size() - base_exp_ar;
    n_got = seen_addr_q.size() - base_seen_ar;
    if (n_got != n_exp) begin
      report($sformatf("Expected %0d AR requests, %0d were issued", n_exp, n_got));
    end
    for (i = 0; i < n_exp && i < n_got; i++) begin
      check_addr($sformatf("m_axi_araddr[%0d]", i), seen_addr_q[base_seen_ar + i],
                 exp_addr_q[base_exp_ar + i]);
      check_len($sformatf("m_axi_arlen[%0d]", i), seen_len_q[base_seen_ar + i],
                exp_len_q[base_exp_ar + i]);
    end
    n_exp = exp_data_q.size() - base_exp_beat;
    n_got = got_data_q.size() - base_got_beat;
    if (n_got != n_exp) begin
      report($sformatf("Expected %0d stream beats, %0d arrived", n_exp, n_got));
    end
    for (i = 0; i < n_exp && i < n_got; i++) begin
      check_data($sformatf("m_axis_tdata[%0d]", i), got_data_q[base_got_beat + i],
                 exp_data_q[base_exp_beat + i]);
      check_last($sformatf("m_axis_tlast[%0d]", i), got_last_q[base_got_beat + i],
                 exp_last_q[base_exp_beat + i]);
    end
    if (done_count - base_done != requests) begin
      report($sformatf("ctrl_done pulsed %0d times for %0d requests",
                       done_count - base_done, requests));
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  task automatic test_single_burst();
    check_last("m_axi_arvalid", m_axi_arvalid, 1'b0);
    check_last("m_axis_tvalid", m_axis_tvalid, 1'b0);
    check_last("ctrl_done", ctrl_done, 1'b0);
    check_last("m_axi_rready", m_axi_rready, 1'b1);
    mark_test_start();
    run_request(32'h0000_4000, 20'd100);
    wait_request_done();
    drain_and_verify(1);
  endtask

  task automatic test_multi_burst();
    mark_test_start();
    run_request(32'h0000_1234, 20'd2600);
    wait_request_done();
    drain_and_verify(1);
  endtask

  // FIFO fills to four bursts and the issuer must stop there
  task automatic test_backpressure();
    sink_mode <= SINK_HOLD;
    mark_test_start();
    run_request(32'h0010_0000, 20'd40960);
    wait_until(WAIT_R, FIFO_BEATS, "FIFO to fill");
    repeat (64) @(posedge aclk);
    if (seen_addr_q.size() - base_seen_ar != MAX_OUTSTANDING) begin
      report($sformatf("%0d bursts issued with the stream stalled",
                       seen_addr_q.size() - base_seen_ar));
    end
    check_last("m_axis_tvalid", m_axis_tvalid, 1'b1);
    if (done_count != base_done) begin
      report("ctrl_done pulsed while the stream was stalled");
    end
    sink_mode <= SINK_OPEN;
    wait_request_done();
    drain_and_verify(1);
  endtask

  // Second start right after the first done while the stream still drains
  task automatic test_back_to_back();
    sink_mode <= SINK_RANDOM;
    mark_test_start();
    run_request(32'h0002_0F00, 20'd5001);
    wait_request_done();
    run_request(32'h0003_07FC, 20'd3);
    wait_request_done();
    drain_and_verify(2);
  endtask

  initial begin
    repeat (5) @(posedge aclk);
    areset <= 1'b0;
    @(posedge aclk);
    test_single_burst();
    test_multi_burst();
    test_backpressure();
    test_back_to_back();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: build.f
hw/axi_rd_pkg.sv
hw/txn_counter.sv
hw/xfer_setup.sv
hw/ar_issue.sv
hw/r_tracker.sv
hw/rdata_fifo.sv
hw/axi_read_master.sv
sim/axi_read_master_props.sv
sim/tb_axi_read_master.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the AXI read master testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
  --top-module tb_axi_read_master -Mdir obj_dir -o sim_axi_read_master
./obj_dir/sim_axi_read_master | tee sim.log

if grep -q "tests failed" sim.log; then
  exit 1
fi
